//--- filelist.f
+incdir+hw
hw/sq_pkg.sv
hw/sq_cmd_decode.sv
hw/sq_entry.sv
hw/sq_check_port.sv
hw/sq_top.sv
verif/sq_clk_gen.sv
verif/sq_tb.sv

//--- hw/sq_check_port.sv
// Store queue load check port
// Compares one load probe against every entry and against the store being
// written this cycle. Match means the store can forward, partial means the
// load overlaps it and has to wait

`timescale 1ns/10ps

`include "sq_config.svh"

module sq_check_port import sq_pkg::*; (
  input  logic                             chk_en,
  input  addr_eo_vec_t                     chk_addr_eo,
  input  odd_code_t                        chk_odd,
  input  byte_mask_t                       chk_bytes,
  input  logic                             chk_bank,
  input  logic                             chk_bank2,
  input  logic                             chk_pre_wrt,
  input  entry_vec_t                       ent_free,
  input  entry_vec_t                       ent_upd,
  input  entry_vec_t                       ent_passe,
  input  odd_code_t  [`SQ_ENTRY_COUNT-1:0] ent_odd,
  input  byte_mask_t [`SQ_ENTRY_COUNT-1:0] ent_bytes,
  input  entry_vec_t                       ent_bank,
  input  entry_vec_t                       ent_bank2,
  input  logic                             wrt_en,
  input  entry_idx_t                       wrt_idx,
  input  odd_code_t                        wrt_odd,
  input  byte_mask_t                       wrt_bytes,
  input  logic                             wrt_bank,
  input  logic                             wrt_bank2,
  output entry_vec_t                       match,
  output entry_vec_t                       partial,
  output logic                             match_w,
  output logic                             partial_w
);

  entry_vec_t base;
  entry_vec_t live;
  entry_vec_t covered;
  logic       base_w;
  logic       live_w;
  logic       covered_w;
  logic       upd_w;

  // Address half, bank2 and odd parity decide whether the two accesses can overlap
  always_comb begin
    for (int e = 0; e < `SQ_ENTRY_COUNT; e++) begin
      base[e] = chk_addr_eo[e][chk_odd[0]] &&
                ((chk_bank2 & ent_bank2[e]) != 1'b0) &&
                (chk_odd[0] == ent_odd[e][0]);
      live[e] = chk_en && !ent_free[e] && !ent_passe[e];
      covered[e] = (chk_bytes & ~ent_bytes[e]) == '0;
    end
  end

  always_comb begin
    for (int e = 0; e < `SQ_ENTRY_COUNT; e++) begin
      match[e] = base[e] && live[e] && covered[e] && ent_upd[e] &&
                 (chk_odd == ent_odd[e]) && ((chk_bank & ent_bank[e]) != 1'b0);
      partial[e] = base[e] && live[e] && (!covered[e] || !ent_upd[e]);
    end
  end

  // In-flight write, using the address compare of the slot being written
  assign base_w = chk_addr_eo[wrt_idx][chk_odd[0]] &&
                  ((chk_bank2 & wrt_bank2) != 1'b0) &&
                  (chk_odd[0] == wrt_odd[0]);
  assign live_w = chk_en && wrt_en && chk_pre_wrt;  // Load must be younger than the store
  assign covered_w = (chk_bytes & ~wrt_bytes) == '0;
  assign upd_w = ent_upd[wrt_idx];

  assign match_w = base_w && live_w && covered_w && upd_w &&
                   (chk_odd == wrt_odd) && ((chk_bank & wrt_bank) != 1'b0);
  assign partial_w = base_w && live_w && (!covered_w || !upd_w);

  // A store either forwards to the load or blocks it, never both
  always_comb begin
    match_partial_excl_a: assert #0 (((match & partial) == '0) && !(match_w && partial_w))
      else $error("match and partial both set");
  end

endmodule

//--- hw/sq_cmd_decode.sv
// Store queue command decoder
// Turns the write, update, retire and free index pulses into one-hot entry
// enables and checks that the commands arriving together are legal

`timescale 1ns/10ps

module sq_cmd_decode import sq_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       wrt_en,
  input  entry_idx_t wrt_idx,
  input  logic       upd_en,
  input  entry_idx_t upd_idx,
  input  logic       passe_en,
  input  entry_idx_t passe_idx,
  input  logic       free_en,
  input  entry_idx_t free_idx,
  output entry_vec_t wrt_sel,
  output entry_vec_t upd_sel,
  output entry_vec_t passe_sel,
  output entry_vec_t free_sel
);

  function automatic entry_vec_t onehot(input logic en, input entry_idx_t idx);
    entry_vec_t vec;
    vec = '0;
    if (en) begin
      vec[idx] = 1'b1;
    end
    return vec;
  endfunction

  assign wrt_sel   = onehot(wrt_en, wrt_idx);
  assign upd_sel   = onehot(upd_en, upd_idx);
  assign passe_sel = onehot(passe_en, passe_idx);
  assign free_sel  = onehot(free_en, free_idx);

  // A store cannot be allocated and released in the same cycle
  wrt_free_same_entry_a: assert property (
    @(posedge clk) disable iff (rst)
    !(wrt_en && free_en && (wrt_idx == free_idx))
  ) else $error("write and free name entry %0d in the same cycle", wrt_idx);

  wrt_idx_known_a: assert property (
    @(posedge clk) disable iff (rst)
    wrt_en |-> !$isunknown(wrt_idx)
  ) else $error("write index unknown while enabled");

  upd_idx_known_a: assert property (
    @(posedge clk) disable iff (rst)
    upd_en |-> !$isunknown(upd_idx)
  ) else $error("update index unknown while enabled");

  passe_idx_known_a: assert property (
    @(posedge clk) disable iff (rst)
    passe_en |-> !$isunknown(passe_idx)
  ) else $error("retire index unknown while enabled");

  free_idx_known_a: assert property (
    @(posedge clk) disable iff (rst)
    free_en |-> !$isunknown(free_idx)
  ) else $error("free index unknown while enabled");

endmodule

//--- hw/sq_config.svh
// Store queue entry tracker configuration
// Sizes of the entry array, the stored fields and the number of load check ports

`ifndef SQ_CONFIG_SVH
`define SQ_CONFIG_SVH

// Number of store queue entries and the width of an entry number
`define SQ_ENTRY_COUNT 16
`define SQ_IDX_WIDTH 4

`define SQ_BYTE_LANES 4    // Byte lanes covered by one store
`define SQ_ODD_WIDTH 4     // Alignment code width

// Even/odd address equality bits supplied per entry by the external comparator
`define SQ_ADDR_EO_WIDTH 2

`define SQ_CHK_PORTS 2     // Load probe ports

`endif

//--- hw/sq_entry.sv
// Store queue entry
// Holds the byte mask, alignment code and bank masks of one store together
// with its free, updated and retired flags

`timescale 1ns/10ps

module sq_entry import sq_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       wrt_sel_bit,
  input  logic       upd_sel_bit,
  input  logic       passe_sel_bit,
  input  logic       free_sel_bit,
  input  odd_code_t  wrt_odd,
  input  byte_mask_t wrt_bytes,
  input  logic       wrt_bank,
  input  logic       wrt_bank2,
  output logic       free,
  output logic       upd,
  output logic       passe,
  output odd_code_t  odd,
  output byte_mask_t bytes,
  output logic       bank,
  output logic       bank2
);

  // Later commands in this block override earlier ones on the same flag
  always_ff @(posedge clk) begin
    if (rst) begin
      free  <= 1'b1;
      upd   <= 1'b1;
      passe <= 1'b0;
    end else begin
      if (wrt_sel_bit) begin
        free  <= 1'b0;  // Data not yet valid until the update arrives
        passe <= 1'b0;
      end
      if (upd_sel_bit) begin
        upd <= 1'b1;
      end
      if (passe_sel_bit) begin
        passe <= 1'b1;
        upd   <= 1'b0;
      end
      if (free_sel_bit) begin
        free  <= 1'b1;
        passe <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wrt_sel_bit) begin
      odd   <= wrt_odd;
      bytes <= wrt_bytes;
      bank  <= wrt_bank;
      bank2 <= wrt_bank2;
    end
  end

  // Only a live store can retire
  retire_live_entry_a: assert property (
    @(posedge clk) disable iff (rst)
    passe_sel_bit |-> !free
  ) else $error("retire applied to a free entry");

endmodule

//--- hw/sq_pkg.sv
// Store queue entry tracker types
// Plain vector types for entry numbers, per-entry vectors and the stored fields

`include "sq_config.svh"

package sq_pkg;

  // Entry number and one-bit-per-entry vector
  typedef logic [`SQ_IDX_WIDTH-1:0] entry_idx_t;
  typedef logic [`SQ_ENTRY_COUNT-1:0] entry_vec_t;

  typedef logic [`SQ_BYTE_LANES-1:0] byte_mask_t;  // Bytes written or read
  typedef logic [`SQ_ODD_WIDTH-1:0] odd_code_t;

  // Bit 0 is the even half, bit 1 the odd half
  typedef logic [`SQ_ADDR_EO_WIDTH-1:0] addr_eo_t;
  typedef addr_eo_t [`SQ_ENTRY_COUNT-1:0] addr_eo_vec_t;

endpackage

//--- hw/sq_top.sv
// Store queue entry tracker
// Command decoder, the array of store entries and the load check ports that
// probe them for forwarding and overlap

`timescale 1ns/10ps

`include "sq_config.svh"

module sq_top import sq_pkg::*; (
  input  logic         clk,
  input  logic         rst,
  input  logic         wrt_en,
  input  entry_idx_t   wrt_idx,
  input  odd_code_t    wrt_odd,
  input  byte_mask_t   wrt_bytes,
  input  logic         wrt_bank,
  input  logic         wrt_bank2,
  input  logic         upd_en,
  input  entry_idx_t   upd_idx,
  input  logic         passe_en,
  input  entry_idx_t   passe_idx,
  input  logic         free_en,
  input  entry_idx_t   free_idx,
  input  logic         chk0_en,
  input  addr_eo_vec_t chk0_addr_eo,
  input  odd_code_t    chk0_odd,
  input  byte_mask_t   chk0_bytes,
  input  logic         chk0_bank,
  input  logic         chk0_bank2,
  input  logic         chk0_pre_wrt,
  output entry_vec_t   chk0_match,
  output entry_vec_t   chk0_partial,
  output logic         chk0_match_w,
  output logic         chk0_partial_w,
  input  logic         chk1_en,
  input  addr_eo_vec_t chk1_addr_eo,
  input  odd_code_t    chk1_odd,
  input  byte_mask_t   chk1_bytes,
  input  logic         chk1_bank,
  input  logic         chk1_bank2,
  input  logic         chk1_pre_wrt,
  output entry_vec_t   chk1_match,
  output entry_vec_t   chk1_partial,
  output logic         chk1_match_w,
  output logic         chk1_partial_w
);

  entry_vec_t wrt_sel;
  entry_vec_t upd_sel;
  entry_vec_t passe_sel;
  entry_vec_t free_sel;

  entry_vec_t                       ent_free;
  entry_vec_t                       ent_upd;
  entry_vec_t                       ent_passe;
  entry_vec_t                       ent_bank;
  entry_vec_t                       ent_bank2;
  odd_code_t  [`SQ_ENTRY_COUNT-1:0] ent_odd;
  byte_mask_t [`SQ_ENTRY_COUNT-1:0] ent_bytes;

  // Probe signals gathered per port so the check ports come from one loop
  logic [`SQ_CHK_PORTS-1:0] p_en;
  logic [`SQ_CHK_PORTS-1:0] p_bank;
  logic [`SQ_CHK_PORTS-1:0] p_bank2;
  logic [`SQ_CHK_PORTS-1:0] p_pre_wrt;
  logic [`SQ_CHK_PORTS-1:0] p_match_w;
  logic [`SQ_CHK_PORTS-1:0] p_partial_w;
  addr_eo_vec_t             p_addr_eo [`SQ_CHK_PORTS];
  odd_code_t                p_odd [`SQ_CHK_PORTS];
  byte_mask_t               p_bytes [`SQ_CHK_PORTS];
  entry_vec_t               p_match [`SQ_CHK_PORTS];
  entry_vec_t               p_partial [`SQ_CHK_PORTS];

  assign p_en      = {chk1_en, chk0_en};
  assign p_bank    = {chk1_bank, chk0_bank};
  assign p_bank2   = {chk1_bank2, chk0_bank2};
  assign p_pre_wrt = {chk1_pre_wrt, chk0_pre_wrt};
  assign p_addr_eo[0] = chk0_addr_eo;
  assign p_addr_eo[1] = chk1_addr_eo;
  assign p_odd[0] = chk0_odd;
  assign p_odd[1] = chk1_odd;
  assign p_bytes[0] = chk0_bytes;
  assign p_bytes[1] = chk1_bytes;

  assign chk0_match     = p_match[0];
  assign chk0_partial   = p_partial[0];
  assign chk0_match_w   = p_match_w[0];
  assign chk0_partial_w = p_partial_w[0];
  assign chk1_match     = p_match[1];
  assign chk1_partial   = p_partial[1];
  assign chk1_match_w   = p_match_w[1];
  assign chk1_partial_w = p_partial_w[1];

  sq_cmd_decode decode_i (
    .clk, .rst,
    .wrt_en, .wrt_idx, .upd_en, .upd_idx,
    .passe_en, .passe_idx, .free_en, .free_idx,
    .wrt_sel, .upd_sel, .passe_sel, .free_sel
  );

  for (genvar e = 0; e < `SQ_ENTRY_COUNT; e++) begin : g_entry
    sq_entry entry_i (
      .clk, .rst,
      .wrt_sel_bit(wrt_sel[e]), .upd_sel_bit(upd_sel[e]),
      .passe_sel_bit(passe_sel[e]), .free_sel_bit(free_sel[e]),
      .wrt_odd, .wrt_bytes, .wrt_bank, .wrt_bank2,
      .free(ent_free[e]), .upd(ent_upd[e]), .passe(ent_passe[e]),
      .odd(ent_odd[e]), .bytes(ent_bytes[e]),
      .bank(ent_bank[e]), .bank2(ent_bank2[e])
    );
  end

  for (genvar p = 0; p < `SQ_CHK_PORTS; p++) begin : g_chk
    sq_check_port chk_i (
      .chk_en(p_en[p]), .chk_addr_eo(p_addr_eo[p]), .chk_odd(p_odd[p]),
      .chk_bytes(p_bytes[p]), .chk_bank(p_bank[p]), .chk_bank2(p_bank2[p]),
      .chk_pre_wrt(p_pre_wrt[p]),
      .ent_free, .ent_upd, .ent_passe, .ent_odd, .ent_bytes, .ent_bank, .ent_bank2,
      .wrt_en, .wrt_idx, .wrt_odd, .wrt_bytes, .wrt_bank, .wrt_bank2,
      .match(p_match[p]), .partial(p_partial[p]),
      .match_w(p_match_w[p]), .partial_w(p_partial_w[p])
    );
  end

endmodule

//--- verif/sq_clk_gen.sv
// Testbench clock and reset generator
// Free-running clock with reset held high for the first rising edges

`timescale 1ns/10ps

module sq_clk_gen #(
  parameter int period_ns    = 10,
  parameter int reset_cycles = 2
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    rst <= 1'b0;  // Released on an edge like any other synchronous input
  end

endmodule

//--- verif/sq_tb.sv
// Store queue entry tracker testbench
// Drives commands and load probes, keeps a reference model of every entry and
// compares both check ports against it on every rising edge

`timescale 1ns/10ps

`include "sq_config.svh"

module sq_tb import sq_pkg::*; ();

  localparam int num_ent       = `SQ_ENTRY_COUNT;
  localparam int num_ports     = `SQ_CHK_PORTS;
  localparam int random_cycles = 150;
  localparam int script_cycles = 200;  // Directed steps plus the random phase
  localparam int max_cycles    = 2 * script_cycles;

  logic       clk;
  logic       rst;
  logic       wrt_en;
  entry_idx_t wrt_idx;
  odd_code_t  wrt_odd;
  byte_mask_t wrt_bytes;
  logic       wrt_bank;
  logic       wrt_bank2;
  logic       upd_en;
  entry_idx_t upd_idx;
  logic       passe_en;
  entry_idx_t passe_idx;
  logic       free_en;
  entry_idx_t free_idx;

  logic [num_ports-1:0] p_en;
  logic [num_ports-1:0] p_bank;
  logic [num_ports-1:0] p_bank2;
  logic [num_ports-1:0] p_pre_wrt;
  addr_eo_vec_t         p_addr_eo [num_ports];
  odd_code_t            p_odd [num_ports];
  byte_mask_t           p_bytes [num_ports];

  entry_vec_t           dut_match [num_ports];
  entry_vec_t           dut_partial [num_ports];
  logic [num_ports-1:0] dut_match_w;
  logic [num_ports-1:0] dut_partial_w;
  entry_vec_t           exp_match [num_ports];
  entry_vec_t           exp_partial [num_ports];
  logic [num_ports-1:0] exp_match_w;
  logic [num_ports-1:0] exp_partial_w;

  // Reference copy of every entry
  entry_vec_t m_free;
  entry_vec_t m_upd;
  entry_vec_t m_passe;
  entry_vec_t m_bank;
  entry_vec_t m_bank2;
  odd_code_t  m_odd [num_ent];
  byte_mask_t m_bytes [num_ent];

  int          cycles = 0;
  int          test_no = 0;
  logic [15:0] lfsr = 16'd49495;
  string       test_names [7] = '{"reset_state", "full_match", "partial", "retire_reuse",
                                  "write_bypass", "independent_ports", "random_probes"};

  sq_clk_gen clk_gen_i (.clk, .rst);

  sq_top dut_i (
    .clk, .rst,
    .wrt_en, .wrt_idx, .wrt_odd, .wrt_bytes, .wrt_bank, .wrt_bank2,
    .upd_en, .upd_idx, .passe_en, .passe_idx, .free_en, .free_idx,
    .chk0_en(p_en[0]), .chk0_addr_eo(p_addr_eo[0]), .chk0_odd(p_odd[0]),
    .chk0_bytes(p_bytes[0]), .chk0_bank(p_bank[0]), .chk0_bank2(p_bank2[0]),
    .chk0_pre_wrt(p_pre_wrt[0]),
    .chk0_match(dut_match[0]), .chk0_partial(dut_partial[0]),
    .chk0_match_w(dut_match_w[0]), .chk0_partial_w(dut_partial_w[0]),
    .chk1_en(p_en[1]), .chk1_addr_eo(p_addr_eo[1]), .chk1_odd(p_odd[1]),
    .chk1_bytes(p_bytes[1]), .chk1_bank(p_bank[1]), .chk1_bank2(p_bank2[1]),
    .chk1_pre_wrt(p_pre_wrt[1]),
    .chk1_match(dut_match[1]), .chk1_partial(dut_partial[1]),
    .chk1_match_w(dut_match_w[1]), .chk1_partial_w(dut_partial_w[1])
  );

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("Finished with errors");
    $fatal(1, "Run stopped on error");
  endtask

  task automatic report_mismatch(input string sig, input int tno,
                                 input logic [31:0] exp_v, input logic [31:0] act_v);
    fail_run($sformatf("MISMATCH test %s: %s expected %h actual %h",
                       test_names[tno], sig, exp_v, act_v));
  endtask

  // Taps 16, 14, 13, 11
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits = {bits[30:0], lfsr_bit()};
    end
    return bits;
  endfunction

  // Returns {match, partial} of one probe against one store
  function automatic logic [1:0] judge(input int p, input addr_eo_t eo, input logic live,
                                       input logic upd, input odd_code_t od,
                                       input byte_mask_t by, input logic bk, input logic bk2);
    logic base;
    logic covered;
    base = eo[p_odd[p][0]] && p_bank2[p] && bk2 && (p_odd[p][0] == od[0]);
    covered = (p_bytes[p] & ~by) == '0;
    if (!(p_en[p] && live && base)) begin
      return 2'b00;
    end
    return {covered && upd && (p_odd[p] == od) && bk && p_bank[p], !covered || !upd};
  endfunction

  always_comb begin
    logic [1:0] r;
    for (int p = 0; p < num_ports; p++) begin
      for (int e = 0; e < num_ent; e++) begin
        r = judge(p, p_addr_eo[p][e], !m_free[e] && !m_passe[e], m_upd[e],
                  m_odd[e], m_bytes[e], m_bank[e], m_bank2[e]);
        exp_match[p][e] = r[1];
        exp_partial[p][e] = r[0];
      end
      r = judge(p, p_addr_eo[p][wrt_idx], wrt_en && p_pre_wrt[p], m_upd[wrt_idx],
                wrt_odd, wrt_bytes, wrt_bank, wrt_bank2);
      exp_match_w[p] = r[1];
      exp_partial_w[p] = r[0];
    end
  end

  // Commands applied lowest priority first so that the stronger one wins
  always @(posedge clk) begin
    if (rst) begin
      m_free  <= '1;
      m_upd   <= '1;
      m_passe <= '0;
    end else begin
      if (wrt_en) begin
        m_free[wrt_idx]  <= 1'b0;
        m_passe[wrt_idx] <= 1'b0;
        m_odd[wrt_idx]   <= wrt_odd;
        m_bytes[wrt_idx] <= wrt_bytes;
        m_bank[wrt_idx]  <= wrt_bank;
        m_bank2[wrt_idx] <= wrt_bank2;
      end
      if (upd_en) begin
        m_upd[upd_idx] <= 1'b1;
      end
      if (passe_en) begin
        m_passe[passe_idx] <= 1'b1;
        m_upd[passe_idx]   <= 1'b0;
      end
      if (free_en) begin
        m_free[free_idx]  <= 1'b1;
        m_passe[free_idx] <= 1'b0;
      end
    end
  end

  for (genvar p = 0; p < num_ports; p++) begin : g_cmp
    match_a: assert property (@(posedge clk) disable iff (rst) dut_match[p] == exp_match[p])
      else report_mismatch($sformatf("chk%0d_match", p), $sampled(test_no),
                           $sampled(exp_match[p]), $sampled(dut_match[p]));
    partial_a: assert property (@(posedge clk) disable iff (rst)
                                dut_partial[p] == exp_partial[p])
      else report_mismatch($sformatf("chk%0d_partial", p), $sampled(test_no),
                           $sampled(exp_partial[p]), $sampled(dut_partial[p]));
    match_w_a: assert property (@(posedge clk) disable iff (rst)
                                dut_match_w[p] == exp_match_w[p])
      else report_mismatch($sformatf("chk%0d_match_w", p), $sampled(test_no),
                           $sampled(exp_match_w[p]), $sampled(dut_match_w[p]));
    partial_w_a: assert property (@(posedge clk) disable iff (rst)
                                  dut_partial_w[p] == exp_partial_w[p])
      else report_mismatch($sformatf("chk%0d_partial_w", p), $sampled(test_no),
                           $sampled(exp_partial_w[p]), $sampled(dut_partial_w[p]));
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      fail_run($sformatf("Timeout: run did not finish within %0d cycles", max_cycles));
    end
  end

  task automatic next_cycle();
    @(posedge clk);
    wrt_en   <= 1'b0;  // Commands are single-cycle pulses
    upd_en   <= 1'b0;
    passe_en <= 1'b0;
    free_en  <= 1'b0;
  endtask

  task automatic write_entry(input entry_idx_t idx, input odd_code_t od, input byte_mask_t by,
                             input logic bk, input logic bk2);
    wrt_en    <= 1'b1;
    wrt_idx   <= idx;
    wrt_odd   <= od;
    wrt_bytes <= by;
    wrt_bank  <= bk;
    wrt_bank2 <= bk2;
  endtask

  // Address compare hits only entry e, or every entry when e is negative
  task automatic probe(input int p, input int e, input odd_code_t od, input byte_mask_t by,
                       input logic bk, input logic bk2, input logic pre);
    addr_eo_vec_t eo;
    eo = (e < 0) ? '1 : '0;
    if (e >= 0) begin
      eo[e] = 2'b11;
    end
    p_en[p]      <= 1'b1;
    p_addr_eo[p] <= eo;
    p_odd[p]     <= od;
    p_bytes[p]   <= by;
    p_bank[p]    <= bk;
    p_bank2[p]   <= bk2;
    p_pre_wrt[p] <= pre;
  endtask

  task automatic random_probe(input int p);
    p_en[p]      <= 1'b1;
    p_addr_eo[p] <= addr_eo_vec_t'(lfsr_bits(32));
    p_odd[p]     <= odd_code_t'(lfsr_bits(4));
    p_bytes[p]   <= byte_mask_t'(lfsr_bits(4));
    p_bank[p]    <= lfsr_bit();
    p_bank2[p]   <= lfsr_bit();
    p_pre_wrt[p] <= lfsr_bit();
  endtask

  initial begin
    entry_idx_t retire_idx;
    {wrt_en, upd_en, passe_en, free_en} = '0;
    {wrt_idx, upd_idx, passe_idx, free_idx} = '0;
    {wrt_odd, wrt_bytes, wrt_bank, wrt_bank2} = '0;
    {p_en, p_bank, p_bank2, p_pre_wrt} = '0;
    for (int p = 0; p < num_ports; p++) begin
      p_addr_eo[p] = '0;
      p_odd[p] = '0;
      p_bytes[p] = '0;
    end
    @(posedge clk);
    while (rst) @(posedge clk);

    next_cycle();
    probe(0, -1, odd_code_t'(lfsr_bits(4)), byte_mask_t'(lfsr_bits(4)), 1'b1, 1'b1, 1'b1);
    probe(1, -1, odd_code_t'(lfsr_bits(4)), byte_mask_t'(lfsr_bits(4)), 1'b1, 1'b1, 1'b1);
    repeat (2) next_cycle();

    next_cycle();
    test_no <= 1;
    p_en <= '0;
    write_entry(4'd3, 4'h2, 4'hf, 1'b1, 1'b1);
    next_cycle();
    probe(0, 3, 4'h2, byte_mask_t'(lfsr_bits(4)), 1'b1, 1'b1, 1'b0);
    next_cycle();

    next_cycle();
    test_no <= 2;
    write_entry(4'd5, 4'h1, 4'h3, 1'b1, 1'b1);
    next_cycle();
    probe(1, 5, 4'h5, 4'hc, 1'b1, 1'b1, 1'b0);  // Upper bytes are missing from the store
    next_cycle();

    next_cycle();
    test_no <= 3;
    passe_en  <= 1'b1;
    passe_idx <= 4'd3;
    next_cycle();
    next_cycle();
    free_en  <= 1'b1;
    free_idx <= 4'd3;
    next_cycle();
    write_entry(4'd3, 4'h2, 4'hf, 1'b1, 1'b1);
    repeat (2) next_cycle();
    upd_en  <= 1'b1;
    upd_idx <= 4'd3;
    next_cycle();

    next_cycle();
    test_no <= 4;
    probe(0, 7, 4'h6, 4'h3, 1'b1, 1'b1, 1'b1);
    write_entry(4'd7, 4'h6, 4'h7, 1'b1, 1'b1);
    next_cycle();
    probe(0, 7, 4'h6, 4'hc, 1'b1, 1'b1, 1'b1);
    write_entry(4'd7, 4'h6, 4'h3, 1'b1, 1'b1);
    next_cycle();
    probe(0, 7, 4'h6, 4'h3, 1'b1, 1'b1, 1'b0);
    write_entry(4'd7, 4'h6, 4'h7, 1'b1, 1'b1);

    next_cycle();
    test_no <= 5;
    probe(0, 3, 4'h2, 4'h1, 1'b1, 1'b1, 1'b0);
    probe(1, 5, 4'h1, 4'h4, 1'b1, 1'b1, 1'b0);
    next_cycle();

    test_no <= 6;
    repeat (random_cycles) begin
      next_cycle();
      random_probe(0);
      random_probe(1);
      if (lfsr_bit()) begin
        write_entry(entry_idx_t'(lfsr_bits(4)), odd_code_t'(lfsr_bits(4)),
                    byte_mask_t'(lfsr_bits(4)), lfsr_bit(), lfsr_bit());
      end
      if (lfsr_bit()) begin
        upd_en  <= 1'b1;
        upd_idx <= entry_idx_t'(lfsr_bits(4));
      end
      if (lfsr_bit()) begin
        retire_idx = entry_idx_t'(lfsr_bits(4));
        if (!m_free[retire_idx]) begin  // Only a live store may retire
          passe_en  <= 1'b1;
          passe_idx <= retire_idx;
        end
      end
    end
    next_cycle();
    p_en <= '0;
    next_cycle();
    @(posedge clk);
    $display("Finished with no errors");
    $finish;
  end

endmodule
